// ==== fpu_mul_defines.svh ====
`ifndef FPU_MUL_DEFINES_SVH
`define FPU_MUL_DEFINES_SVH

`define FPM_EXP_BIAS 127            // Binary32 exponent bias.
`define FPM_WORD_W   32
`define FPM_SIG_W    24             // Significand with hidden bit.
`define FPM_EXP_W    10             // Signed working exponent.
`define FPM_PROD_W   48             // Full fraction product.
`define FPM_LDZ_W    6

`define FPM_QNAN     32'h7FC00000   // Canonical quiet NaN.

`endif

// ==== fpu_mul_pkg.sv ====
`include "fpu_mul_defines.svh"

package fpu_mul_pkg;

	// ------------------------------------------------------------
	// Datapath vectors
	// ------------------------------------------------------------
	typedef logic [`FPM_WORD_W-1:0] fp32_t;

	typedef logic [`FPM_SIG_W-1:0] fpm_sig_t;

	// Binary point sits below bit 46.
	typedef logic [`FPM_PROD_W-1:0] fpm_prod_t;

	// Biased, but allowed to go negative or above 255 before packing.
	typedef logic signed [`FPM_EXP_W-1:0] fpm_exp_t;

	typedef logic [`FPM_LDZ_W-1:0] fpm_ldz_t;   // Leading zeros plus one.

	// ------------------------------------------------------------
	// Operand and result class
	// ------------------------------------------------------------
	typedef enum logic [1:0]
	{
		FPM_NUM,
		FPM_ZERO,
		FPM_INF,
		FPM_NAN
	} fpm_class_e;

endpackage

// ==== fpm_stage_if.sv ====
`timescale 1ns/1ns

interface fpm_stage_if;
	import fpu_mul_pkg::*;

	logic       valid;         // Item strobe, no handshake.
	logic       sign;
	fpm_exp_t   exp;
	fpm_prod_t  prod;          // Stage 1 packs both significands here.
	fpm_class_e cls;

	modport src
	(
		output valid,
		output sign,
		output exp,
		output prod,
		output cls
	);

	modport dst
	(
		input valid,
		input sign,
		input exp,
		input prod,
		input cls
	);

endinterface

// ==== fpm_unpack.sv ====
`timescale 1ns/1ns
`include "fpu_mul_defines.svh"

module fpm_unpack
(
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	input  fpu_mul_pkg::fp32_t a,
	input  fpu_mul_pkg::fp32_t b,
	fpm_stage_if.src           out
);
	import fpu_mul_pkg::*;

	logic [7:0]  exp_a;
	logic [7:0]  exp_b;
	logic [7:0]  eff_a;
	logic [7:0]  eff_b;
	logic        nan_a, inf_a, zero_a;
	logic        nan_b, inf_b, zero_b;
	fpm_sig_t    sig_a;
	fpm_sig_t    sig_b;
	fpm_exp_t    exp_sum;
	fpm_class_e  cls_d;

	assign exp_a = a[30:23];
	assign exp_b = b[30:23];

	// Denormals use an effective exponent of 1 and no hidden bit.
	assign eff_a = (exp_a == 8'd0) ? 8'd1 : exp_a;
	assign eff_b = (exp_b == 8'd0) ? 8'd1 : exp_b;
	assign sig_a = {(exp_a != 8'd0), a[22:0]};
	assign sig_b = {(exp_b != 8'd0), b[22:0]};

	assign exp_sum = fpm_exp_t'({2'b00, eff_a}) + fpm_exp_t'({2'b00, eff_b})
		- fpm_exp_t'(`FPM_EXP_BIAS);

	assign nan_a  = (exp_a == 8'hFF) && (a[22:0] != 23'd0);
	assign inf_a  = (exp_a == 8'hFF) && (a[22:0] == 23'd0);
	assign zero_a = (exp_a == 8'h00) && (a[22:0] == 23'd0);
	assign nan_b  = (exp_b == 8'hFF) && (b[22:0] != 23'd0);
	assign inf_b  = (exp_b == 8'hFF) && (b[22:0] == 23'd0);
	assign zero_b = (exp_b == 8'h00) && (b[22:0] == 23'd0);

	always_comb
	begin
		if (nan_a || nan_b || (inf_a && zero_b) || (inf_b && zero_a))
			cls_d = FPM_NAN;
		else if (inf_a || inf_b)
			cls_d = FPM_INF;
		else if (zero_a || zero_b)
			cls_d = FPM_ZERO;
		else
			cls_d = FPM_NUM;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out.valid <= 1'b0;
		else
			out.valid <= in_valid;
		out.sign <= a[31] ^ b[31];
		out.exp  <= exp_sum;
		out.prod <= {sig_a, sig_b};
		out.cls  <= cls_d;
	end

endmodule

// ==== fpm_fract_mul.sv ====
`timescale 1ns/1ns

module fpm_fract_mul
(
	input  logic     clk,
	input  logic     rst,
	fpm_stage_if.dst in,
	fpm_stage_if.src out
);
	import fpu_mul_pkg::*;

	fpm_sig_t  sig_a;
	fpm_sig_t  sig_b;
	fpm_prod_t prod;

	// Significands arrive side by side in the upper and lower halves.
	assign sig_a = in.prod[47:24];
	assign sig_b = in.prod[23:0];

	assign prod = fpm_prod_t'(sig_a) * fpm_prod_t'(sig_b);   // Two integer bits above bit 46.

	always_ff @(posedge clk)
	begin
		if (rst)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
		out.sign <= in.sign;
		out.exp  <= in.exp;
		out.prod <= prod;
		out.cls  <= in.cls;
	end

endmodule

// ==== pri_encoder.sv ====
`timescale 1ns/1ns
`include "fpu_mul_defines.svh"

module pri_encoder
(
	input  fpu_mul_pkg::fpm_prod_t fract_in,
	output fpu_mul_pkg::fpm_ldz_t  fi_ldz
);
	import fpu_mul_pkg::*;

	// Position of the first one counted from bit 47, starting at 1.
	// An all-zero word reports the full width.
	always_comb
	begin
		logic found;

		found  = 1'b0;
		fi_ldz = fpm_ldz_t'(`FPM_PROD_W);
		for (int i = `FPM_PROD_W - 1; i >= 0; i--)
		begin
			if (!found && fract_in[i])
			begin
				found  = 1'b1;
				fi_ldz = fpm_ldz_t'(`FPM_PROD_W - i);
			end
		end
	end

endmodule

// ==== fpm_normalize.sv ====
`timescale 1ns/1ns

module fpm_normalize
(
	input  logic     clk,
	input  logic     rst,
	fpm_stage_if.dst in,
	fpm_stage_if.src out
);
	import fpu_mul_pkg::*;

	fpm_ldz_t  fi_ldz;
	fpm_ldz_t  shift;
	fpm_prod_t prod_norm;
	fpm_exp_t  exp_norm;

	pri_encoder pri_encoder_i
	(
		.fract_in (in.prod),
		.fi_ldz   (fi_ldz)
	);

	// ------------------------------------------------------------
	// Leading one to bit 47
	// ------------------------------------------------------------
	assign shift     = fi_ldz - fpm_ldz_t'(1);
	assign prod_norm = in.prod << shift;

	// One at bit 47 means the product was in [2,4).
	assign exp_norm = in.exp + fpm_exp_t'(2) - fpm_exp_t'({4'b0000, fi_ldz});

	always_ff @(posedge clk)
	begin
		if (rst)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
		out.sign <= in.sign;
		out.exp  <= exp_norm;
		out.prod <= prod_norm;
		out.cls  <= in.cls;
	end

endmodule

// ==== fpm_round_pack.sv ====
`timescale 1ns/1ns
`include "fpu_mul_defines.svh"

module fpm_round_pack
(
	input  logic               clk,
	input  logic               rst,
	fpm_stage_if.dst           in,
	output logic               out_valid,
	output fpu_mul_pkg::fp32_t result
);
	import fpu_mul_pkg::*;

	fp32_t signed_zero;
	fp32_t signed_inf;
	fp32_t packed_num;
	fp32_t result_d;

	assign signed_zero = {in.sign, 31'd0};
	assign signed_inf  = {in.sign, 8'hFF, 23'd0};

	// Truncation, bits below 24 are dropped.
	assign packed_num = {in.sign, in.exp[7:0], in.prod[46:24]};

	always_comb
	begin
		case (in.cls)
			FPM_NAN:
				result_d = `FPM_QNAN;
			FPM_INF:
				result_d = signed_inf;
			FPM_ZERO:
				result_d = signed_zero;
			default:
			begin
				if (in.exp <= fpm_exp_t'(0))
					result_d = signed_zero;              // Flush, no denormal output.
				else if (in.exp >= fpm_exp_t'(255))
					result_d = signed_inf;
				else
					result_d = packed_num;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= in.valid;
		result <= result_d;
	end

endmodule

// ==== fpu_mul.sv ====
`timescale 1ns/1ns

module fpu_mul
(
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	input  fpu_mul_pkg::fp32_t a,
	input  fpu_mul_pkg::fp32_t b,
	output logic               out_valid,
	output fpu_mul_pkg::fp32_t result
);

	fpm_stage_if s1 ();    // Unpack to multiply.
	fpm_stage_if s2 ();    // Multiply to normalize.
	fpm_stage_if s3 ();    // Normalize to pack.

	fpm_unpack fpm_unpack_i
	(
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.out      (s1.src)
	);

	fpm_fract_mul fpm_fract_mul_i
	(
		.clk (clk),
		.rst (rst),
		.in  (s1.dst),
		.out (s2.src)
	);

	fpm_normalize fpm_normalize_i
	(
		.clk (clk),
		.rst (rst),
		.in  (s2.dst),
		.out (s3.src)
	);

	fpm_round_pack fpm_round_pack_i
	(
		.clk       (clk),
		.rst       (rst),
		.in        (s3.dst),
		.out_valid (out_valid),
		.result    (result)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;    // 100 ns period.
	end

endmodule

// ==== fpm_tb_ref.svh ====
`ifndef FPM_TB_REF_SVH
`define FPM_TB_REF_SVH

// Expected binary32 product, truncated, flushed below the normal range.
function automatic fp32_t fpm_ref_mul(fp32_t x, fp32_t y);
	logic [7:0]  ex;
	logic [7:0]  ey;
	logic [22:0] fx;
	logic [22:0] fy;
	logic        sgn;
	logic        x_nan, x_inf, x_zero;
	logic        y_nan, y_inf, y_zero;
	logic [47:0] m;
	logic [47:0] aligned;
	int          p;
	int          e;

	ex     = x[30:23];
	ey     = y[30:23];
	fx     = x[22:0];
	fy     = y[22:0];
	sgn    = x[31] ^ y[31];
	x_nan  = (ex == 8'hFF) && (fx != 23'd0);
	x_inf  = (ex == 8'hFF) && (fx == 23'd0);
	x_zero = (ex == 8'h00) && (fx == 23'd0);
	y_nan  = (ey == 8'hFF) && (fy != 23'd0);
	y_inf  = (ey == 8'hFF) && (fy == 23'd0);
	y_zero = (ey == 8'h00) && (fy == 23'd0);

	if (x_nan || y_nan || (x_inf && y_zero) || (y_inf && x_zero))
		return `FPM_QNAN;
	if (x_inf || y_inf)
		return {sgn, 8'hFF, 23'd0};
	if (x_zero || y_zero)
		return {sgn, 31'd0};

	m = {24'd0, (ex != 8'd0), fx} * {24'd0, (ey != 8'd0), fy};
	p = 0;
	for (int i = 0; i < 48; i++)
	begin
		if (m[i])
			p = i;                     // Highest set bit wins.
	end

	// Value is m * 2^(Ex + Ey - 254 - 46), denormals counted at exponent 1.
	e = p - 46 + ((ex == 8'd0) ? 1 : int'(ex)) + ((ey == 8'd0) ? 1 : int'(ey)) - 127;
	if (e <= 0)
		return {sgn, 31'd0};
	if (e >= 255)
		return {sgn, 8'hFF, 23'd0};
	if (p >= 23)
		aligned = m >> (p - 23);
	else
		aligned = m << (23 - p);
	return {sgn, e[7:0], aligned[22:0]};
endfunction

`endif

// ==== fpu_mul_tb.sv ====
`timescale 1ns/1ns
`include "fpu_mul_defines.svh"

module fpu_mul_tb;
	import fpu_mul_pkg::*;

	`include "fpm_tb_ref.svh"

	logic  clk;
	logic  rst;
	logic  in_valid;
	fp32_t a;
	fp32_t b;
	logic  out_valid;
	fp32_t result;

	fp32_t exp_q[$];               // Expected words in input order.
	int    stamp_q[$];             // Edge count at which each input was taken.
	int    cycle = 0;
	logic  gaps_on;
	int    result_errs = 0;
	int    latency_errs = 0;
	int    proto_errs = 0;
	int    timeout_errs = 0;

	tb_clock_gen tb_clock_gen_i (.clk (clk));

	fpu_mul fpu_mul_i
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result)
	);

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	task automatic check_result(fp32_t expected, fp32_t actual);
		if (actual !== expected)
		begin
			$display("** Error result: expected %h, actual %h at %0t", expected, actual, $time);
			result_errs++;
		end
	endtask

	task automatic check_latency(int expected, int actual);
		if (actual != expected)
		begin
			$display("Result arrived %0d cycles after its input instead of %0d", actual, expected);
			latency_errs++;
		end
	endtask

	// Outputs read here were registered one edge earlier.
	always @(posedge clk)
	begin
		if (rst && (out_valid === 1'b1))
		begin
			$display("out_valid went high while reset was held");
			proto_errs++;
		end
		else if (out_valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				$display("A result appeared with no input waiting for it");
				proto_errs++;
			end
			else
			begin
				check_result(exp_q.pop_front(), result);
				check_latency(4, cycle - stamp_q.pop_front());
			end
		end
		if (!rst && in_valid)
		begin
			exp_q.push_back(fpm_ref_mul(a, b));
			stamp_q.push_back(cycle);
		end
		cycle = cycle + 1;
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	task automatic idle(int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			#10;
			in_valid = 1'b0;
			a = $urandom;                  // Garbage while idle.
			b = $urandom;
		end
	endtask

	task automatic send(fp32_t x, fp32_t y);
		idle(gaps_on ? int'($urandom_range(2)) : 0);
		@(posedge clk);
		#10;
		in_valid = 1'b1;
		a = x;
		b = y;
	endtask

	function automatic fp32_t rand_normal(int lo, int hi);
		return {1'($urandom), 8'($urandom_range(hi, lo)), 23'($urandom)};
	endfunction

	// Fraction with exactly k leading zeros.
	function automatic logic [22:0] denorm_frac(int k);
		logic [22:0] lead;
		lead = 23'h400000 >> k;
		return lead | (23'($urandom) & (lead - 23'd1));
	endfunction

	task automatic run_normal(int n);
		for (int i = 0; i < n; i++)
			send(rand_normal(100, 154), rand_normal(100, 154));
	endtask

	task automatic run_denormal();
		fp32_t x;
		fp32_t y;
		for (int k = 0; k < 23; k++)
		begin
			x = {1'($urandom), 8'h00, denorm_frac(k)};
			send(x, rand_normal(127, 254));
			send(rand_normal(1, 254), x);
			send(x, {1'($urandom), 8'h00, denorm_frac(k)});
			y = {1'($urandom), 8'h00, denorm_frac(int'($urandom_range(22)))};
			send(y, x);
		end
	endtask

	task automatic run_range(int n);
		int ea;
		int eb;
		for (int i = 0; i < n; i++)
		begin
			ea = int'($urandom_range(254, 127));
			eb = 381 - ea + int'($urandom_range(4)) - 2;      // Near the overflow edge.
			if (eb > 254)
				eb = 254;
			send({1'($urandom), 8'(ea), 23'($urandom)}, {1'($urandom), 8'(eb), 23'($urandom)});
			ea = int'($urandom_range(126, 1));
			eb = 127 - ea + int'($urandom_range(4)) - 2;      // Near the underflow edge.
			if (eb < 1)
				eb = 1;
			send({1'($urandom), 8'(ea), 23'($urandom)}, {1'($urandom), 8'(eb), 23'($urandom)});
			send(rand_normal(200, 254), rand_normal(200, 254));
			send(rand_normal(1, 50), rand_normal(1, 50));
		end
	endtask

	task automatic run_special(int n);
		fp32_t nan_w;
		fp32_t inf_w;
		fp32_t zero_w;
		fp32_t num_w;
		fp32_t den_w;
		for (int i = 0; i < n; i++)
		begin
			nan_w  = {1'($urandom), 8'hFF, 23'($urandom) | 23'd1};
			inf_w  = {1'($urandom), 8'hFF, 23'd0};
			zero_w = {1'($urandom), 31'd0};
			num_w  = rand_normal(1, 254);
			den_w  = {1'($urandom), 8'h00, denorm_frac(int'($urandom_range(22)))};
			send(nan_w, num_w);
			send(num_w, nan_w);
			send(inf_w, zero_w);
			send(zero_w, inf_w);
			send(inf_w, num_w);
			send(den_w, inf_w);
			send(zero_w, num_w);
			send(den_w, zero_w);
			send(inf_w, inf_w);
			send(nan_w, inf_w);
		end
	endtask

	initial
	begin
		int waited;

		rst      = 1'b1;
		in_valid = 1'b1;                       // Offered during reset, must be dropped.
		a        = '0;
		b        = '0;
		gaps_on  = 1'b0;
		void'($urandom(32'h86310109));

		repeat (10) @(posedge clk);
		#10;
		rst      = 1'b0;
		in_valid = 1'b0;
		idle(3);

		run_normal(200);                       // Back to back.
		run_denormal();
		run_range(40);
		run_special(8);
		gaps_on = 1'b1;                        // Random idle gaps from here on.
		run_normal(100);
		run_special(4);
		run_denormal();
		idle(1);

		waited = 0;
		while ((exp_q.size() != 0) && (waited < 20))
		begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Timed out with %0d results still outstanding", exp_q.size());
			timeout_errs++;
		end
		repeat (8) @(negedge clk);

		$display("Errors: result %0d, latency %0d, protocol %0d, timeout %0d",
			result_errs, latency_errs, proto_errs, timeout_errs);
		if ((result_errs + latency_errs + proto_errs + timeout_errs) == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== fpu_mul.f ====
+incdir+.
fpu_mul_pkg.sv
fpm_stage_if.sv
fpm_unpack.sv
fpm_fract_mul.sv
pri_encoder.sv
fpm_normalize.sv
fpm_round_pack.sv
fpu_mul.sv
tb_clock_gen.sv
fpu_mul_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fpu_mul_tb
FLIST     ?= fpu_mul.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/1ns -j 0

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
